//--- source/mips_settings.svh
//*************************************************
// global sizes for the single-cycle mips core
// data width other than 32 is not supported by the
// instruction formats; dmem depth must be a power of 2
//*************************************************

`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// machine word width
`define MIPS_DATA_W 32

// architectural register count
`define MIPS_REG_COUNT 32

// register number width, follows the register count
`define MIPS_REG_AW $clog2(`MIPS_REG_COUNT)

// data memory depth in words
`define MIPS_DMEM_WORDS 256

`endif

//--- source/mips_pkg.sv
//*************************************************
// shared types for the mips subset core
// only add, sub, and, or, slt, addi, lw, sw, beq
//*************************************************

`include "mips_settings.svh"

package mips_pkg;

  // primary opcodes kept in this subset
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_BEQ   = 6'h04,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  // r-type function codes
  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_e;

  typedef struct packed {
    opcode_e                  opcode;
    logic [`MIPS_REG_AW-1:0]  rs;
    logic [`MIPS_REG_AW-1:0]  rt;
    logic [`MIPS_REG_AW-1:0]  rd;
    logic [4:0]               shamt;
    funct_e                   funct;
  } instr_r_t;

  typedef struct packed {
    opcode_e                  opcode;
    logic [`MIPS_REG_AW-1:0]  rs;
    logic [`MIPS_REG_AW-1:0]  rt;
    logic [15:0]              imm;
  } instr_i_t;

  // one instruction word, seen as either format
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // classic 3-bit alu control encoding
  typedef enum logic [2:0] {
    ALU_AND = 3'b000,
    ALU_OR  = 3'b001,
    ALU_ADD = 3'b010,
    ALU_SUB = 3'b110,
    ALU_SLT = 3'b111
  } alu_op_e;

  typedef struct packed {
    logic    reg_write;
    logic    reg_dst;
    logic    alu_src;
    logic    branch;
    logic    mem_write;
    logic    mem_to_reg;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic                    we;
    logic [`MIPS_REG_AW-1:0] num;
    logic [`MIPS_DATA_W-1:0] data;
  } reg_write_t;

  // addr is a byte address
  typedef struct packed {
    logic                    we;
    logic [`MIPS_DATA_W-1:0] addr;
    logic [`MIPS_DATA_W-1:0] data;
  } mem_write_t;

endpackage

//--- source/mips_control.sv
//*************************************************
// main decoder and alu decoder in one block
// any encoding outside the subset decodes as a nop
//*************************************************

`timescale 1ns/1ps

module mips_control (
  input  mips_pkg::instr_u instr,
  output mips_pkg::ctrl_t  ctrl
);

  import mips_pkg::*;

  always_comb begin
    // nop unless a known encoding is found
    ctrl.reg_write  = 1'b0;
    ctrl.reg_dst    = 1'b0;
    ctrl.alu_src    = 1'b0;
    ctrl.branch     = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.mem_to_reg = 1'b0;
    ctrl.alu_op     = ALU_ADD;

    case (instr.i.opcode)
      OP_RTYPE: begin
        ctrl.reg_dst = 1'b1;
        // funct comes from the r-type view of the same word
        case (instr.r.funct)
          FN_ADD: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALU_ADD;
          end
          FN_SUB: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALU_SUB;
          end
          FN_AND: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALU_AND;
          end
          FN_OR: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALU_OR;
          end
          FN_SLT: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALU_SLT;
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_ADDI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      OP_LW: begin
        ctrl.reg_write  = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      OP_BEQ: begin
        // compare by subtraction, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;
      end
      default: ctrl.branch = 1'b0;
    endcase
  end

endmodule

//--- source/mips_alu.sv
//*************************************************
// combinational alu, slt compares as signed
// no overflow detection
//*************************************************

`timescale 1ns/1ps

`include "mips_settings.svh"

module mips_alu (
  input  logic [`MIPS_DATA_W-1:0] a,
  input  logic [`MIPS_DATA_W-1:0] b,
  input  mips_pkg::alu_op_e       op,
  output logic [`MIPS_DATA_W-1:0] result,
  output logic                    zero
);

  import mips_pkg::*;

  always_comb begin
    case (op)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      // 1 or 0 in the low bit
      ALU_SLT: begin
        result = '0;
        result[0] = ($signed(a) < $signed(b));
      end
      default: result = '0;
    endcase
  end

  // beq relies on this after a subtract
  assign zero = (result == '0);

endmodule

//--- source/mips_register_file.sv
//*************************************************
// two combinational read ports, one clocked write
// register zero always reads 0, writes to it are lost
//*************************************************

`timescale 1ns/1ps

`include "mips_settings.svh"

module mips_register_file (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [`MIPS_REG_AW-1:0] ra1,
  input  logic [`MIPS_REG_AW-1:0] ra2,
  output logic [`MIPS_DATA_W-1:0] rd1,
  output logic [`MIPS_DATA_W-1:0] rd2,
  input  mips_pkg::reg_write_t    wr
);

  logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_COUNT];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we && (wr.num != '0)) begin
      regs[wr.num] <= wr.data;
    end
  end

  // hard-wired zero on both ports
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

//--- source/mips_data_memory.sv
//*************************************************
// word-addressed data ram, byte address in
// addr[1:0] and bits above the depth are ignored
//*************************************************

`timescale 1ns/1ps

`include "mips_settings.svh"

module mips_data_memory (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [`MIPS_DATA_W-1:0] addr,
  output logic [`MIPS_DATA_W-1:0] rdata,
  input  mips_pkg::mem_write_t    wr
);

  localparam int WORD_AW = $clog2(`MIPS_DMEM_WORDS);

  logic [`MIPS_DATA_W-1:0] mem [`MIPS_DMEM_WORDS];
  logic [WORD_AW-1:0]      rd_idx;
  logic [WORD_AW-1:0]      wr_idx;

  // word index starts at bit 2
  assign rd_idx = addr[WORD_AW+1:2];
  assign wr_idx = wr.addr[WORD_AW+1:2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr.we) begin
      mem[wr_idx] <= wr.data;
    end
  end

  assign rdata = mem[rd_idx];

endmodule

//--- source/mips_cpu.sv
//*************************************************
// single-cycle datapath, one instruction per clock
// instruction memory is external and must answer
// instr_addr in the same cycle
//*************************************************

`timescale 1ns/1ps

`include "mips_settings.svh"

module mips_cpu (
  input  logic                    clk,
  input  logic                    arst_n,
  output logic [`MIPS_DATA_W-1:0] instr_addr,
  input  logic [`MIPS_DATA_W-1:0] instr_data,
  output logic [`MIPS_REG_AW-1:0] rf_ra1,
  output logic [`MIPS_REG_AW-1:0] rf_ra2,
  input  logic [`MIPS_DATA_W-1:0] rf_rd1,
  input  logic [`MIPS_DATA_W-1:0] rf_rd2,
  output mips_pkg::reg_write_t    rf_wr,
  output logic [`MIPS_DATA_W-1:0] mem_addr,
  input  logic [`MIPS_DATA_W-1:0] mem_rdata,
  output mips_pkg::mem_write_t    mem_wr
);

  import mips_pkg::*;

  logic [`MIPS_DATA_W-1:0] pc;
  logic [`MIPS_DATA_W-1:0] pc_plus4;
  logic [`MIPS_DATA_W-1:0] pc_branch;
  logic [`MIPS_DATA_W-1:0] pc_next;
  logic                    pc_src;

  instr_u                  instr;
  ctrl_t                   ctrl;
  logic [`MIPS_REG_AW-1:0] write_num;
  logic [`MIPS_DATA_W-1:0] sign_imm;
  logic [`MIPS_DATA_W-1:0] src_b;
  logic [`MIPS_DATA_W-1:0] alu_result;
  logic                    alu_zero;
  logic [`MIPS_DATA_W-1:0] result;

  // fetch
  assign instr_addr = pc;
  assign instr      = instr_data;

  mips_control mips_control_i (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // register read numbers come straight from the word
  assign rf_ra1 = instr.i.rs;
  assign rf_ra2 = instr.i.rt;

  // destination is rd for r-type, rt otherwise
  assign write_num = ctrl.reg_dst ? instr.r.rd : instr.i.rt;

  assign sign_imm = {{(`MIPS_DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
  assign src_b    = ctrl.alu_src ? sign_imm : rf_rd2;

  mips_alu mips_alu_i (
    .a      (rf_rd1),
    .b      (src_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // memory access
  assign mem_addr = alu_result;

  // write-back select
  assign result = ctrl.mem_to_reg ? mem_rdata : alu_result;

  // no state changes while reset is held
  always_comb begin
    rf_wr.we   = ctrl.reg_write & arst_n;
    rf_wr.num  = write_num;
    rf_wr.data = result;

    mem_wr.we   = ctrl.mem_write & arst_n;
    mem_wr.addr = alu_result;
    mem_wr.data = rf_rd2;
  end

  // next pc
  assign pc_plus4  = pc + `MIPS_DATA_W'(4);
  assign pc_branch = pc_plus4 + (sign_imm << 2);
  assign pc_src    = ctrl.branch & alu_zero;
  assign pc_next   = pc_src ? pc_branch : pc_plus4;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

//--- source/mips_system.sv
//*************************************************
// top level: core, register file and data ram
// instruction memory lives outside, fetch is
// combinational through instr_addr / instr_data
//*************************************************

`timescale 1ns/1ps

`include "mips_settings.svh"

module mips_system (
  input  logic                    clk,
  input  logic                    arst_n,
  output logic [`MIPS_DATA_W-1:0] instr_addr,
  input  logic [`MIPS_DATA_W-1:0] instr_data,
  output logic [`MIPS_DATA_W-1:0] pc,
  output mips_pkg::reg_write_t    reg_write,
  output mips_pkg::mem_write_t    mem_write
);

  import mips_pkg::*;

  logic [`MIPS_REG_AW-1:0] rf_ra1;
  logic [`MIPS_REG_AW-1:0] rf_ra2;
  logic [`MIPS_DATA_W-1:0] rf_rd1;
  logic [`MIPS_DATA_W-1:0] rf_rd2;
  reg_write_t              rf_wr;
  logic [`MIPS_DATA_W-1:0] mem_addr;
  logic [`MIPS_DATA_W-1:0] mem_rdata;
  mem_write_t              mem_wr;

  mips_cpu mips_cpu_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .rf_ra1     (rf_ra1),
    .rf_ra2     (rf_ra2),
    .rf_rd1     (rf_rd1),
    .rf_rd2     (rf_rd2),
    .rf_wr      (rf_wr),
    .mem_addr   (mem_addr),
    .mem_rdata  (mem_rdata),
    .mem_wr     (mem_wr)
  );

  mips_register_file mips_register_file_i (
    .clk    (clk),
    .arst_n (arst_n),
    .ra1    (rf_ra1),
    .ra2    (rf_ra2),
    .rd1    (rf_rd1),
    .rd2    (rf_rd2),
    .wr     (rf_wr)
  );

  mips_data_memory mips_data_memory_i (
    .clk    (clk),
    .arst_n (arst_n),
    .addr   (mem_addr),
    .rdata  (mem_rdata),
    .wr     (mem_wr)
  );

  // pc is the fetch address
  assign pc = instr_addr;

  // write ports mirrored out for observation
  assign reg_write = rf_wr;
  assign mem_write = mem_wr;

endmodule

//--- tb/mips_system_tb.sv
//*************************************************
// testbench for mips_system, serves each pattern
// line's word as the fetched instruction
// must run from the project root to find patterns
//*************************************************

`timescale 1ns/1ps

`include "mips_settings.svh"

module mips_system_tb;

  import mips_pkg::*;

  // one pattern line
  typedef struct packed {
    logic                    rst_n;
    logic [`MIPS_DATA_W-1:0] pc;
    logic [`MIPS_DATA_W-1:0] instr;
    reg_write_t              rw;
    mem_write_t              mw;
  } cycle_t;

  logic                    clk;
  logic                    arst_n;
  logic [`MIPS_DATA_W-1:0] instr_addr;
  logic [`MIPS_DATA_W-1:0] instr_data;
  logic [`MIPS_DATA_W-1:0] pc;
  reg_write_t              reg_write;
  mem_write_t              mem_write;

  cycle_t cycles[$];
  string  test_names[$];
  int     test_first[$];
  int     error_count = 0;
  int     pass_count = 0;
  int     fail_count = 0;
  bit     loaded = 1'b0;

  mips_system mips_system_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .pc         (pc),
    .reg_write  (reg_write),
    .mem_write  (mem_write)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // limit is pattern lines plus reset plus margin, in clock periods
  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = (cycles.size() + 3 + 20) * 100;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic string strip_line(input string s);
    string t;
    t = s;
    while (t.len() > 0 && (t[t.len()-1] == 8'h0a || t[t.len()-1] == 8'h0d ||
                           t[t.len()-1] == 8'h20)) begin
      t = t.substr(0, t.len() - 2);
    end
    return t;
  endfunction

  task automatic load_patterns(output bit ok);
    int                      fd;
    int                      n;
    string                   line;
    cycle_t                  c;
    logic [`MIPS_DATA_W-1:0] v_rst, v_pc, v_instr, v_rwe, v_rnum;
    logic [`MIPS_DATA_W-1:0] v_rdata, v_mwe, v_maddr, v_mdata;
    ok = 1'b1;
    fd = $fopen("tb/mips_system_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file tb/mips_system_patterns.txt");
      ok = 1'b0;
      return;
    end
    while (ok && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      line = strip_line(line);
      if (line.len() == 0 || line[0] == "#") begin
        continue;
      end
      if (line.len() > 5 && line.substr(0, 4) == "test ") begin
        test_names.push_back(line.substr(5, line.len() - 1));
        test_first.push_back(cycles.size());
      end else begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", v_rst, v_pc, v_instr,
                    v_rwe, v_rnum, v_rdata, v_mwe, v_maddr, v_mdata);
        if (n != 9 || test_names.size() == 0) begin
          $display("pattern line could not be read: %s", line);
          ok = 1'b0;
        end else begin
          c.rst_n   = v_rst[0];
          c.pc      = v_pc;
          c.instr   = v_instr;
          c.rw.we   = v_rwe[0];
          c.rw.num  = v_rnum[`MIPS_REG_AW-1:0];
          c.rw.data = v_rdata;
          c.mw.we   = v_mwe[0];
          c.mw.addr = v_maddr;
          c.mw.data = v_mdata;
          cycles.push_back(c);
        end
      end
    end
    $fclose(fd);
    if (ok && cycles.size() == 0) begin
      $display("the pattern file holds no cycles");
      ok = 1'b0;
    end
  endtask

  task automatic compare_word(input string name, input logic [`MIPS_DATA_W-1:0] got,
                              input logic [`MIPS_DATA_W-1:0] exp, input int idx);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h (cycle %0d)", name, got, exp, idx);
      error_count++;
    end
  endtask

  // number and data only matter when a write is expected
  task automatic compare_reg_write(input reg_write_t got, input reg_write_t exp,
                                   input int idx);
    if (got.we !== exp.we) begin
      $display("[ERROR] reg_write.we: got 0x%0h, expected 0x%0h (cycle %0d)",
               got.we, exp.we, idx);
      error_count++;
    end else if (exp.we) begin
      if (got.num !== exp.num) begin
        $display("[ERROR] reg_write.num: got 0x%02h, expected 0x%02h (cycle %0d)",
                 got.num, exp.num, idx);
        error_count++;
      end
      compare_word("reg_write.data", got.data, exp.data, idx);
    end
  endtask

  task automatic compare_mem_write(input mem_write_t got, input mem_write_t exp,
                                   input int idx);
    if (got.we !== exp.we) begin
      $display("[ERROR] mem_write.we: got 0x%0h, expected 0x%0h (cycle %0d)",
               got.we, exp.we, idx);
      error_count++;
    end else if (exp.we) begin
      compare_word("mem_write.addr", got.addr, exp.addr, idx);
      compare_word("mem_write.data", got.data, exp.data, idx);
    end
  endtask

  // drive after the edge, check mid-cycle once fetch has settled
  task automatic run_cycle(input int idx);
    cycle_t c;
    c = cycles[idx];
    @(posedge clk);
    #5;
    arst_n     = c.rst_n;
    instr_data = c.instr;
    @(negedge clk);
    compare_word("pc", pc, c.pc, idx);
    compare_word("instr_addr", instr_addr, c.pc, idx);
    compare_reg_write(reg_write, c.rw, idx);
    compare_mem_write(mem_write, c.mw, idx);
  endtask

  task automatic run_test(input int t);
    int first;
    int last;
    int errors_before;
    first = test_first[t];
    last  = (t + 1 < test_first.size()) ? test_first[t + 1] : cycles.size();
    errors_before = error_count;
    for (int i = first; i < last; i++) begin
      run_cycle(i);
    end
    if (error_count == errors_before) begin
      pass_count++;
      $display("test %s: pass", test_names[t]);
    end else begin
      fail_count++;
      $display("test %s: fail, %0d errors", test_names[t], error_count - errors_before);
    end
  endtask

  initial begin
    bit ok;
    arst_n     = 1'b0;
    instr_data = '0;
    load_patterns(ok);
    if (ok) begin
      loaded = 1'b1;
      for (int t = 0; t < test_names.size(); t++) begin
        run_test(t);
      end
    end else begin
      error_count++;
    end
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (error_count == 0 && fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- tb/mips_system_patterns.txt
# columns, all hex: arst_n pc instr reg_write.we .num .data mem_write.we .addr .data
# a line "test <name>" opens a group; num, addr and data are ignored when we is 0
test reset
0 00000000 20010055 0 00 00000000 0 00000000 00000000
0 00000000 ac010000 0 00 00000000 0 00000000 00000000
0 00000000 20010055 0 00 00000000 0 00000000 00000000
test immediate
1 00000000 20010005 1 01 00000005 0 00000000 00000000
1 00000004 2002fffd 1 02 fffffffd 0 00000000 00000000
1 00000008 20230010 1 03 00000015 0 00000000 00000000
1 0000000c 2044fff0 1 04 ffffffed 0 00000000 00000000
test rtype
1 00000010 00232820 1 05 0000001a 0 00000000 00000000
1 00000014 00233022 1 06 fffffff0 0 00000000 00000000
1 00000018 00643824 1 07 00000005 0 00000000 00000000
1 0000001c 00224025 1 08 fffffffd 0 00000000 00000000
1 00000020 0041482a 1 09 00000001 0 00000000 00000000
1 00000024 0022502a 1 0a 00000000 0 00000000 00000000
1 00000028 0082582a 1 0b 00000001 0 00000000 00000000
test load_store
1 0000002c 200c0040 1 0c 00000040 0 00000000 00000000
1 00000030 ad850008 0 00 00000000 1 00000048 0000001a
1 00000034 ad86fffc 0 00 00000000 1 0000003c fffffff0
1 00000038 8d8d0008 1 0d 0000001a 0 00000000 00000000
1 0000003c 8d8efffc 1 0e fffffff0 0 00000000 00000000
1 00000040 8d8f0000 1 0f 00000000 0 00000000 00000000
test branch
1 00000044 10270002 0 00 00000000 0 00000000 00000000
1 00000050 10220005 0 00 00000000 0 00000000 00000000
1 00000054 20100001 1 10 00000001 0 00000000 00000000
1 00000058 1209fffc 0 00 00000000 0 00000000 00000000
1 0000004c 10000003 0 00 00000000 0 00000000 00000000
test reg_zero
1 0000005c 20000077 1 00 00000077 0 00000000 00000000
1 00000060 00019020 1 12 00000005 0 00000000 00000000
1 00000064 00009825 1 13 00000000 0 00000000 00000000
1 00000068 100a0001 0 00 00000000 0 00000000 00000000
1 00000070 ad800000 0 00 00000000 1 00000040 00000000

//--- mips_system.f
+incdir+source
source/mips_pkg.sv
source/mips_control.sv
source/mips_alu.sv
source/mips_register_file.sv
source/mips_data_memory.sv
source/mips_cpu.sv
source/mips_system.sv
tb/mips_system_tb.sv

//--- run_mips_system.sh
#!/bin/sh
# builds the mips_system testbench with verilator, runs it, checks the log
cd "$(dirname "$0")" || exit 1
LOG=mips_system_sim.log

verilator --binary --timing -f mips_system.f --top-module mips_system_tb \
  && ./obj_dir/Vmips_system_tb > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "SOME TESTS FAILED" "$LOG" && { echo "simulation result: failing"; exit 1; }
echo "simulation result: passing"
exit 0
